// ==== rv6_exec_top.f ====
+incdir+bench
rtl/rv6_exec_pkg.sv
rtl/mem_if.sv
rtl/alu.sv
rtl/int_pipe.sv
rtl/lsu.sv
rtl/amo_unit.sv
rtl/mem_arbiter.sv
rtl/data_ram.sv
rtl/rv6_exec_top.sv
bench/rv6_exec_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run rv6_exec_tb with Verilator; the result is read from sim.log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module rv6_exec_tb -f rv6_exec_top.f \
    -o rv6_exec_sim > build.log 2>&1 || { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/rv6_exec_sim > sim.log 2>&1
grep -q "Simulation finished: FAIL" sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
grep -q "Simulation finished: PASS" sim.log && echo "Simulation passed" && exit 0
echo "No result in sim.log"
exit 1

// ==== bench/exec_model.svh ====
/*
 * Reference model of the execution cluster datapath.
 * ALU result per opcode and the new memory value of an AMO.
 */

`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

// New memory value, old is memory, src is rs2.
function automatic word_t amo_model(word_t old_val, word_t src, logic [4:0] f5);
    case (f5)
        amo_swap: return src;
        amo_add:  return old_val + src;
        amo_xor:  return old_val ^ src;
        amo_and:  return old_val & src;
        amo_or:   return old_val | src;
        amo_min:  return ($signed(old_val) <= $signed(src)) ? old_val : src;
        amo_max:  return ($signed(old_val) >= $signed(src)) ? old_val : src;
        amo_minu: return (old_val <= src) ? old_val : src;
        amo_maxu: return (old_val >= src) ? old_val : src;
        default:  return '0;
    endcase
endfunction

function automatic word_t alu_model(word_t a, word_t b, op_ir_t ir);
    logic [6:0] opc;
    logic [2:0] f3;
    logic       alt;
    word_t      wide;
    opc = ir[6:0];
    f3  = ir[9:7];
    alt = ir[13];
    if (opc == op_lui) return b;
    if (opc == op_amo) return amo_model(a, b, ir[14:10]);
    if (opc == op_system) return ir[9] ? b : a;
    // W forms, done at 64 bits, low word kept.
    if (opc == op_itype_w || opc == op_rtype_w) begin
        if (f3 == 3'd1) begin
            wide = word_t'(a[31:0]) << b[4:0];
        end else if (f3 == 3'd5 && alt) begin
            wide = $signed({{32{a[31]}}, a[31:0]}) >>> b[4:0];
        end else if (f3 == 3'd5) begin
            wide = word_t'(a[31:0]) >> b[4:0];
        end else if (f3 == 3'd0 && opc == op_rtype_w && alt) begin
            wide = a - b;
        end else begin
            wide = a + b;
        end
        return {{32{wide[31]}}, wide[31:0]};
    end
    if (opc != op_itype && opc != op_rtype) return a + b;
    case (f3)
        3'd0: return (opc == op_rtype && alt) ? a - b : a + b;
        3'd1: return a << b[5:0];
        3'd2: return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
        3'd3: return (a < b) ? 64'd1 : 64'd0;
        3'd4: return a ^ b;
        3'd5: begin
            if (alt) wide = $signed(a) >>> b[5:0];
            else wide = a >> b[5:0];
            return wide;
        end
        3'd6: return a | b;
        default: return a & b;
    endcase
endfunction

`endif

// ==== bench/rv6_exec_tb.sv ====
/*
 * Testbench for the RV6 execution cluster.
 * Random pipe ops, loads, stores and AMOs checked against a local model.
 */

`timescale 1ns/1ps
`default_nettype none

module rv6_exec_tb;
    import rv6_exec_pkg::*;

    `include "exec_model.svh"

    // Test lengths in operations.
    localparam int     init_ops   = ram_words;
    localparam int     int_ops    = 200;
    localparam int     w_ops      = 64;
    localparam int     ls_pairs   = 48;
    localparam int     amo_pairs  = 48;
    localparam int     par_rounds = 48;
    localparam int     total_ops  = init_ops + int_ops + w_ops
                                  + 2 * (ls_pairs + amo_pairs + par_rounds);
    // 20 cycles of 10 ns per operation, plus reset.
    localparam longint watchdog_ns = longint'(total_ops) * 200 + 100;
    localparam int     seed        = 32'h1445_0338;

    logic   clk = 1'b0;
    logic   arst_n;
    logic   int_valid;
    op_ir_t int_op_ir;
    word_t  int_a;
    word_t  int_b;
    word_t  int_result;
    logic   int_result_valid;
    logic   ls_start;
    logic   ls_we;
    word_t  ls_base;
    word_t  ls_offset;
    word_t  ls_wdata;
    logic   ls_busy;
    logic   ls_done;
    word_t  ls_rdata;
    logic   amo_start;
    op_ir_t amo_op_ir;
    word_t  amo_addr;
    word_t  amo_src;
    logic   amo_busy;
    logic   amo_done;
    word_t  amo_rdata;

    // Memory model and pipe scoreboard.
    word_t      model_mem [ram_words];
    word_t      exp_q [$];
    string      name_q [$];
    logic [1:0] rv_hist = '0;

    always #5 clk = ~clk;

    rv6_exec_top i_dut (.*);

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    task automatic abort_run();
        $display("Simulation finished: FAIL");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Mismatch %s: expected %b, actual %b", name, expected, actual);
            abort_run();
        end
    endtask

    // Result valid two edges after issue, checked every cycle.
    always @(negedge clk) begin
        if (arst_n) begin
            check_flag("int_result_valid timing", rv_hist[1], int_result_valid);
            if (int_result_valid && exp_q.size() == 0) begin
                $display("Error: int_result_valid with no operation in flight");
                abort_run();
            end
            if (int_result_valid) check_word(name_q.pop_front(), exp_q.pop_front(), int_result);
            rv_hist = {rv_hist[0], int_valid};
        end
    end

    initial begin
        #(watchdog_ns);
        $display("Timeout: the run did not complete within %0d ns", watchdog_ns);
        abort_run();
    end

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    function automatic logic [6:0] pick_opcode(int unsigned sel);
        case (sel)
            0: return op_itype;
            1: return op_itype_w;
            2: return op_rtype;
            3: return op_rtype_w;
            4: return op_lui;
            5: return op_amo;
            default: return op_system;
        endcase
    endfunction

    function automatic logic [4:0] pick_amo(int unsigned sel);
        case (sel)
            0: return amo_swap;
            1: return amo_add;
            2: return amo_xor;
            3: return amo_and;
            4: return amo_or;
            5: return amo_min;
            6: return amo_max;
            7: return amo_minu;
            default: return amo_maxu;
        endcase
    endfunction

    task automatic int_issue(input op_ir_t ir, input word_t a, input word_t b, input string name);
        @(posedge clk);
        int_valid <= 1'b1;
        int_op_ir <= ir;
        int_a     <= a;
        int_b     <= b;
        exp_q.push_back(alu_model(a, b, ir));
        name_q.push_back(name);
    endtask

    task automatic drain_int_pipe();
        @(posedge clk);
        int_valid <= 1'b0;
        while (exp_q.size() != 0) @(negedge clk);
    endtask

    // One lsu access, base and offset split at random.
    task automatic ls_access(input logic we, input mem_addr_t idx, input word_t wdata,
                             input string name);
        word_t ea;
        word_t off;
        word_t expected;
        ea       = word_t'(idx) << 3;
        off      = word_t'($urandom_range(511, 0)) << 3;
        expected = model_mem[idx];
        @(posedge clk);
        ls_start  <= 1'b1;
        ls_we     <= we;
        ls_base   <= ea - off;
        ls_offset <= off;
        ls_wdata  <= wdata;
        @(posedge clk);
        ls_start <= 1'b0;
        do begin
            @(negedge clk);
        end while (!ls_done);
        check_flag({name, " busy at done"}, 1'b1, ls_busy);
        if (we) model_mem[idx] = wdata;
        else check_word(name, expected, ls_rdata);
        @(negedge clk);
        check_flag({name, " busy after done"}, 1'b0, ls_busy);
    endtask

    task automatic amo_access(input logic [4:0] f5, input mem_addr_t idx, input word_t src,
                              input string name);
        word_t old_val;
        old_val = model_mem[idx];
        @(posedge clk);
        amo_start <= 1'b1;
        amo_op_ir <= {f5, 3'b011, op_amo};
        amo_addr  <= word_t'(idx) << 3;
        amo_src   <= src;
        @(posedge clk);
        amo_start <= 1'b0;
        do begin
            @(negedge clk);
        end while (!amo_done);
        check_flag({name, " busy at done"}, 1'b1, amo_busy);
        check_word({name, " old value"}, old_val, amo_rdata);
        model_mem[idx] = amo_model(old_val, src, f5);
        @(negedge clk);
        check_flag({name, " busy after done"}, 1'b0, amo_busy);
    endtask

    initial begin
        mem_addr_t   li;
        mem_addr_t   ai;
        logic        lw;
        logic [4:0]  code;
        op_ir_t      ir;
        word_t       d0;
        word_t       d1;
        int unsigned s;
        void'($urandom(seed));
        arst_n    = 1'b0;
        int_valid = 1'b0;
        int_op_ir = '0;
        int_a     = '0;
        int_b     = '0;
        ls_start  = 1'b0;
        ls_we     = 1'b0;
        ls_base   = '0;
        ls_offset = '0;
        ls_wdata  = '0;
        amo_start = 1'b0;
        amo_op_ir = '0;
        amo_addr  = '0;
        amo_src   = '0;
        model_mem = '{default: '0};
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;

        // RAM powers up unknown, every word gets its own address pattern.
        for (int i = 0; i < init_ops; i++) begin
            ls_access(1'b1, mem_addr_t'(i), {8{mem_addr_t'(i)}}, "fill");
        end

        // Back to back ops over every opcode.
        for (int i = 0; i < int_ops; i++) begin
            ir      = op_ir_t'($urandom);
            ir[6:0] = pick_opcode($urandom_range(6, 0));
            int_issue(ir, {$urandom, $urandom}, {$urandom, $urandom}, "int_random");
        end
        drain_int_pipe();

        // W forms with bit 31 set, small shift or add operand.
        for (int i = 0; i < w_ops; i++) begin
            ir      = op_ir_t'($urandom);
            ir[6:0] = ($urandom_range(1, 0) == 0) ? op_itype_w : op_rtype_w;
            s       = $urandom_range(2, 0);
            ir[9:7] = (s == 0) ? 3'd0 : (s == 1) ? 3'd1 : 3'd5;
            d0      = {$urandom, $urandom} | 64'h8000_0000;
            int_issue(ir, d0, {$urandom, 32'($urandom_range(31, 0))}, "int_wform");
        end
        drain_int_pipe();

        // Stores then loads, lsu region.
        for (int i = 0; i < ls_pairs; i++) begin
            li = mem_addr_t'($urandom_range(127, 0));
            ls_access(1'b1, li, {$urandom, $urandom}, "ls_store");
            if ($urandom_range(1, 0) == 1) li = mem_addr_t'($urandom_range(127, 0));
            ls_access(1'b0, li, '0, "ls_load");
        end

        // Each AMO, then a swap that reads back its new value.
        for (int i = 0; i < amo_pairs; i++) begin
            ai = mem_addr_t'($urandom_range(255, 128));
            amo_access(pick_amo($urandom_range(8, 0)), ai, {$urandom, $urandom}, "amo_op");
            amo_access(amo_swap, ai, {$urandom, $urandom}, "amo_readback");
        end

        // Both agents started on the same edge.
        for (int i = 0; i < par_rounds; i++) begin
            li   = mem_addr_t'($urandom_range(127, 0));
            ai   = mem_addr_t'($urandom_range(255, 128));
            lw   = 1'($urandom_range(1, 0));
            code = pick_amo($urandom_range(8, 0));
            d0   = {$urandom, $urandom};
            d1   = {$urandom, $urandom};
            fork
                ls_access(lw, li, d0, "par_ls");
                amo_access(code, ai, d1, "par_amo");
            join
        end

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== rtl/rv6_exec_top.sv ====
/*
 * RV6 execution cluster top.
 * Integer pipe, lsu and AMO unit, the latter two sharing one data RAM.
 */

`timescale 1ns/1ps
`default_nettype none

module rv6_exec_top (
    input  logic                 clk,
    input  logic                 arst_n,
    // Integer pipe.
    input  logic                 int_valid,
    input  rv6_exec_pkg::op_ir_t int_op_ir,
    input  rv6_exec_pkg::word_t  int_a,
    input  rv6_exec_pkg::word_t  int_b,
    output rv6_exec_pkg::word_t  int_result,
    output logic                 int_result_valid,
    // Load/store.
    input  logic                 ls_start,
    input  logic                 ls_we,
    input  rv6_exec_pkg::word_t  ls_base,
    input  rv6_exec_pkg::word_t  ls_offset,
    input  rv6_exec_pkg::word_t  ls_wdata,
    output logic                 ls_busy,
    output logic                 ls_done,
    output rv6_exec_pkg::word_t  ls_rdata,
    // Atomics.
    input  logic                 amo_start,
    input  rv6_exec_pkg::op_ir_t amo_op_ir,
    input  rv6_exec_pkg::word_t  amo_addr,
    input  rv6_exec_pkg::word_t  amo_src,
    output logic                 amo_busy,
    output logic                 amo_done,
    output rv6_exec_pkg::word_t  amo_rdata
);

    logic lock;

    // Agent ports and the RAM port.
    mem_if ls_mem  ();
    mem_if amo_mem ();
    mem_if ram_mem ();

    int_pipe u_int_pipe (
        .clk              (clk),
        .arst_n           (arst_n),
        .int_valid        (int_valid),
        .int_op_ir        (int_op_ir),
        .int_a            (int_a),
        .int_b            (int_b),
        .int_result       (int_result),
        .int_result_valid (int_result_valid)
    );

    lsu u_lsu (
        .clk       (clk),
        .arst_n    (arst_n),
        .ls_start  (ls_start),
        .ls_we     (ls_we),
        .ls_base   (ls_base),
        .ls_offset (ls_offset),
        .ls_wdata  (ls_wdata),
        .ls_busy   (ls_busy),
        .ls_done   (ls_done),
        .ls_rdata  (ls_rdata),
        .mem       (ls_mem.master)
    );

    amo_unit u_amo_unit (
        .clk       (clk),
        .arst_n    (arst_n),
        .amo_start (amo_start),
        .amo_op_ir (amo_op_ir),
        .amo_addr  (amo_addr),
        .amo_src   (amo_src),
        .amo_busy  (amo_busy),
        .amo_done  (amo_done),
        .lock      (lock),
        .amo_rdata (amo_rdata),
        .mem       (amo_mem.master)
    );

    // lsu on m0, AMO unit on m1.
    mem_arbiter u_mem_arbiter (
        .clk    (clk),
        .arst_n (arst_n),
        .lock   (lock),
        .m0     (ls_mem.slave),
        .m1     (amo_mem.slave),
        .ram    (ram_mem.master)
    );

    data_ram u_data_ram (
        .clk  (clk),
        .port (ram_mem.slave)
    );

endmodule

`default_nettype wire

// ==== rtl/data_ram.sv ====
/*
 * Single-port doubleword data RAM.
 * Always grants, synchronous write, registered read.
 */

`timescale 1ns/1ps
`default_nettype none

module data_ram (
    input logic  clk,
    mem_if.slave port
);
    import rv6_exec_pkg::*;

    word_t mem_q [ram_words];
    word_t rdata_q;

    // No wait states.
    assign port.gnt   = port.req;
    assign port.rdata = rdata_q;

    always_ff @(posedge clk) begin
        if (port.req && port.we) begin
            mem_q[port.addr] <= port.wdata;
        end
        // Read data valid the cycle after grant.
        if (port.req && !port.we) begin
            rdata_q <= mem_q[port.addr];
        end
    end

endmodule

`default_nettype wire

// ==== rtl/mem_arbiter.sv ====
/*
 * Two-master round-robin memory arbiter.
 * m0 is the lsu, m1 the AMO unit, which can lock the port.
 */

`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
    input  logic  clk,
    input  logic  arst_n,
    input  logic  lock,
    mem_if.slave  m0,
    mem_if.slave  m1,
    mem_if.master ram
);

    logic sel0;
    logic sel1;
    // Last winner, also owner of the pending read data.
    logic last_m1;

    // Lock pins the port on m1, otherwise alternate on conflict.
    always_comb begin
        sel0 = 1'b0;
        sel1 = 1'b0;
        if (lock) begin
            sel1 = m1.req;
        end else if (m0.req && m1.req) begin
            sel0 = last_m1;
            sel1 = !last_m1;
        end else begin
            sel0 = m0.req;
            sel1 = m1.req;
        end
    end

    // Request mux.
    assign ram.req   = sel0 || sel1;
    assign ram.we    = sel1 ? m1.we    : m0.we;
    assign ram.addr  = sel1 ? m1.addr  : m0.addr;
    assign ram.wdata = sel1 ? m1.wdata : m0.wdata;

    assign m0.gnt = sel0 && ram.gnt;
    assign m1.gnt = sel1 && ram.gnt;

    // Reset value puts the lsu first.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            last_m1 <= 1'b1;
        end else if (ram.req && ram.gnt) begin
            last_m1 <= sel1;
        end
    end

    // Read data goes back to the previous winner only.
    assign m0.rdata = last_m1 ? '0 : ram.rdata;
    assign m1.rdata = last_m1 ? ram.rdata : '0;

    a_one_gnt: assert property (@(posedge clk) disable iff (!arst_n)
        !(m0.gnt && m1.gnt))
        else $error("mem_arbiter: both masters granted");

endmodule

`default_nettype wire

// ==== rtl/amo_unit.sv ====
/*
 * Atomic memory operation engine.
 * Read, modify in a local ALU, write back while holding the arbiter lock.
 */

`timescale 1ns/1ps
`default_nettype none

module amo_unit (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 amo_start,
    input  rv6_exec_pkg::op_ir_t amo_op_ir,
    input  rv6_exec_pkg::word_t  amo_addr,
    input  rv6_exec_pkg::word_t  amo_src,
    output logic                 amo_busy,
    output logic                 amo_done,
    output logic                 lock,
    output rv6_exec_pkg::word_t  amo_rdata,
    mem_if.master                mem
);
    import rv6_exec_pkg::*;

    typedef enum logic [1:0] {st_idle, st_rreq, st_rdata, st_wreq} amo_state_t;

    amo_state_t state;
    mem_addr_t  addr_q;
    word_t      src_q;
    op_ir_t     op_q;
    word_t      old_q;
    word_t      new_val;
    logic       accept;

    assign amo_busy = (state != st_idle) || amo_done;
    assign accept   = amo_start && !amo_busy;
    // Held from just after the read grant to the write grant.
    assign lock     = (state == st_rdata) || (state == st_wreq);

    ////////////////////////////////////////////////////////////
    // Sequencer
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= st_idle;
            amo_done <= 1'b0;
        end else begin
            amo_done <= 1'b0;
            case (state)
                st_idle: begin
                    if (accept) state <= st_rreq;
                end
                st_rreq: begin
                    if (mem.gnt) state <= st_rdata;
                end
                // Old value lands here.
                st_rdata: state <= st_wreq;
                st_wreq: begin
                    if (mem.gnt) begin
                        state    <= st_idle;
                        amo_done <= 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Operands, old value. Opcode forced to AMO for the local ALU.
    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= amo_addr[addr_w+2:3];
            src_q  <= amo_src;
            op_q   <= {amo_op_ir[op_ir_w-1:7], op_amo};
        end
        if (state == st_rdata) old_q <= mem.rdata;
    end

    alu u_alu (
        .a       (old_q),
        .b       (src_q),
        .op_ir   (op_q),
        .alu_out (new_val)
    );

    assign mem.req   = (state == st_rreq) || (state == st_wreq);
    assign mem.we    = (state == st_wreq);
    assign mem.addr  = addr_q;
    assign mem.wdata = new_val;
    assign amo_rdata = old_q;

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    a_start_idle: assert property (@(posedge clk) disable iff (!arst_n)
        amo_start |-> !amo_busy)
        else $error("amo_unit: amo_start while busy");

    // Nothing may slip in between read and write.
    a_lock_hold: assert property (@(posedge clk) disable iff (!arst_n)
        (mem.gnt && !mem.we) |=> lock ##1 (lock && mem.gnt && mem.we))
        else $error("amo_unit: write not granted under lock");

endmodule

`default_nettype wire

// ==== rtl/lsu.sv ====
/*
 * Doubleword load/store unit.
 * One access per start, base plus offset, through a shared memory port.
 */

`timescale 1ns/1ps
`default_nettype none

module lsu (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                ls_start,
    input  logic                ls_we,
    input  rv6_exec_pkg::word_t ls_base,
    input  rv6_exec_pkg::word_t ls_offset,
    input  rv6_exec_pkg::word_t ls_wdata,
    output logic                ls_busy,
    output logic                ls_done,
    output rv6_exec_pkg::word_t ls_rdata,
    mem_if.master               mem
);
    import rv6_exec_pkg::*;

    typedef enum logic [1:0] {st_idle, st_req, st_rdata} lsu_state_t;

    lsu_state_t state;
    mem_addr_t  addr_q;
    logic       we_q;
    word_t      wdata_q;
    word_t      ea;
    logic       accept;

    // Effective byte address.
    assign ea     = ls_base + ls_offset;
    // Busy covers the done cycle too.
    assign ls_busy = (state != st_idle) || ls_done;
    assign accept  = ls_start && !ls_busy;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= st_idle;
            ls_done <= 1'b0;
        end else begin
            ls_done <= 1'b0;
            case (state)
                st_idle: begin
                    if (accept) state <= st_req;
                end
                st_req: begin
                    // Stores finish on the grant edge.
                    if (mem.gnt) begin
                        state   <= we_q ? st_idle : st_rdata;
                        ls_done <= we_q;
                    end
                end
                st_rdata: begin
                    state   <= st_idle;
                    ls_done <= 1'b1;
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Request fields and load data.
    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q  <= ea[addr_w+2:3];
            we_q    <= ls_we;
            wdata_q <= ls_wdata;
        end
        if (state == st_rdata) ls_rdata <= mem.rdata;
    end

    assign mem.req   = (state == st_req);
    assign mem.we    = we_q;
    assign mem.addr  = addr_q;
    assign mem.wdata = wdata_q;

    // No new access while one is in flight.
    a_start_idle: assert property (@(posedge clk) disable iff (!arst_n)
        ls_start |-> !ls_busy)
        else $error("lsu: ls_start while busy");

endmodule

`default_nettype wire

// ==== rtl/int_pipe.sv ====
/*
 * Two-stage integer pipe around the ALU.
 * Operands in, registered result out two edges later.
 */

`timescale 1ns/1ps
`default_nettype none

module int_pipe (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 int_valid,
    input  rv6_exec_pkg::op_ir_t int_op_ir,
    input  rv6_exec_pkg::word_t  int_a,
    input  rv6_exec_pkg::word_t  int_b,
    output rv6_exec_pkg::word_t  int_result,
    output logic                 int_result_valid
);
    import rv6_exec_pkg::*;

    logic   s1_valid;
    op_ir_t s1_op_ir;
    word_t  s1_a;
    word_t  s1_b;
    word_t  alu_res;

    // Valid chain, one bit per stage.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid         <= 1'b0;
            int_result_valid <= 1'b0;
        end else begin
            s1_valid         <= int_valid;
            int_result_valid <= s1_valid;
        end
    end

    // Stage payloads.
    always_ff @(posedge clk) begin
        if (int_valid) begin
            s1_op_ir <= int_op_ir;
            s1_a     <= int_a;
            s1_b     <= int_b;
        end
        if (s1_valid) begin
            int_result <= alu_res;
        end
    end

    alu u_alu (
        .a       (s1_a),
        .b       (s1_b),
        .op_ir   (s1_op_ir),
        .alu_out (alu_res)
    );

endmodule

`default_nettype wire

// ==== rtl/alu.sv ====
/*
 * 64-bit integer ALU.
 * Covers I, R, W, LUI, SYSTEM and the AMO modify step, purely combinational.
 */

`timescale 1ns/1ps
`default_nettype none

module alu (
    input  rv6_exec_pkg::word_t  a,
    input  rv6_exec_pkg::word_t  b,
    input  rv6_exec_pkg::op_ir_t op_ir,
    output rv6_exec_pkg::word_t  alu_out
);
    import rv6_exec_pkg::*;

    logic [6:0]  opc;
    logic [2:0]  f3;
    logic [4:0]  f5;
    logic        alt;
    logic [31:0] w_res;
    word_t       amo_res;

    // Field split.
    assign opc = op_ir[6:0];
    assign f3  = op_ir[ir_f3_lo +: 3];
    assign f5  = op_ir[ir_f5_lo +: 5];
    assign alt = op_ir[ir_alt_bit];

    // Low word of the W forms, extended below.
    always_comb begin
        case (f3)
            3'b000:  w_res = (opc == op_rtype_w && alt) ? a[31:0] - b[31:0]
                                                        : a[31:0] + b[31:0];
            3'b001:  w_res = a[31:0] << b[4:0];
            3'b101:  w_res = alt ? $unsigned($signed(a[31:0]) >>> b[4:0])
                                 : a[31:0] >> b[4:0];
            default: w_res = a[31:0] + b[31:0];
        endcase
    end

    // Modify step, a is memory, b is rs2.
    always_comb begin
        case (f5)
            amo_swap: amo_res = b;
            amo_add:  amo_res = a + b;
            amo_xor:  amo_res = a ^ b;
            amo_and:  amo_res = a & b;
            amo_or:   amo_res = a | b;
            amo_min:  amo_res = ($signed(a) < $signed(b)) ? a : b;
            amo_max:  amo_res = ($signed(a) > $signed(b)) ? a : b;
            amo_minu: amo_res = (a < b) ? a : b;
            amo_maxu: amo_res = (a > b) ? a : b;
            default:  amo_res = '0;
        endcase
    end

    // Opcode select. Anything unknown falls back to add.
    always_comb begin
        case (opc)
            op_lui:    alu_out = b;
            op_amo:    alu_out = amo_res;
            op_system: alu_out = op_ir[ir_sys_bit] ? b : a;
            op_itype, op_rtype: begin
                case (f3)
                    3'b000:  alu_out = (opc == op_rtype && alt) ? a - b : a + b;
                    3'b001:  alu_out = a << b[5:0];
                    3'b010:  alu_out = word_t'($signed(a) < $signed(b));
                    3'b011:  alu_out = word_t'(a < b);
                    3'b100:  alu_out = a ^ b;
                    3'b101:  alu_out = alt ? $unsigned($signed(a) >>> b[5:0]) : a >> b[5:0];
                    3'b110:  alu_out = a | b;
                    default: alu_out = a & b;
                endcase
            end
            op_itype_w, op_rtype_w: alu_out = {{32{w_res[31]}}, w_res};
            default:   alu_out = a + b;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/mem_if.sv ====
/*
 * Single memory port bundle.
 * Agent side drives the request, the memory side answers with grant and data.
 */

`timescale 1ns/1ps
`default_nettype none

interface mem_if;
    import rv6_exec_pkg::*;

    // Request fields, held steady until gnt.
    logic      req;
    logic      we;
    mem_addr_t addr;
    word_t     wdata;
    // Grant this cycle, read data one cycle later.
    logic      gnt;
    word_t     rdata;

    modport master (
        output req, we, addr, wdata,
        input  gnt, rdata
    );

    modport slave (
        input  req, we, addr, wdata,
        output gnt, rdata
    );

endinterface

`default_nettype wire

// ==== rtl/rv6_exec_pkg.sv ====
/*
 * RV6 execution cluster shared definitions.
 * Data width, opcode map, op_ir field layout, AMO codes and RAM geometry.
 */

`default_nettype none

package rv6_exec_pkg;

    ////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////

    // Integer datapath width.
    localparam int xlen    = 64;
    // Compressed instruction field carried with every op.
    localparam int op_ir_w = 15;

    // op_ir layout: opcode in [6:0], funct3 in [9:7], funct5 in [14:10].
    localparam int ir_f3_lo   = 7;
    localparam int ir_f5_lo   = 10;
    // Subtract / arithmetic shift select.
    localparam int ir_alt_bit = 13;
    // SYSTEM source select, a or b.
    localparam int ir_sys_bit = 9;

    ////////////////////////////////////////////////////////////
    // Opcodes and AMO function codes
    ////////////////////////////////////////////////////////////

    localparam logic [6:0] op_itype   = 7'b0010011;
    localparam logic [6:0] op_itype_w = 7'b0011011;
    localparam logic [6:0] op_rtype   = 7'b0110011;
    localparam logic [6:0] op_rtype_w = 7'b0111011;
    localparam logic [6:0] op_lui     = 7'b0110111;
    localparam logic [6:0] op_amo     = 7'b0101111;
    localparam logic [6:0] op_system  = 7'b1110011;

    // AMO funct5 encodings.
    localparam logic [4:0] amo_swap = 5'b00001;
    localparam logic [4:0] amo_add  = 5'b00000;
    localparam logic [4:0] amo_xor  = 5'b00100;
    localparam logic [4:0] amo_and  = 5'b01100;
    localparam logic [4:0] amo_or   = 5'b01000;
    localparam logic [4:0] amo_min  = 5'b10000;
    localparam logic [4:0] amo_max  = 5'b10100;
    localparam logic [4:0] amo_minu = 5'b11000;
    localparam logic [4:0] amo_maxu = 5'b11100;

    // Data RAM depth in doublewords.
    localparam int ram_words = 256;
    localparam int addr_w    = $clog2(ram_words);

    typedef logic [xlen-1:0]    word_t;
    typedef logic [op_ir_w-1:0] op_ir_t;
    typedef logic [addr_w-1:0]  mem_addr_t;

endpackage

`default_nettype wire
